//--- common/rs_params.svh
`ifndef RS_PARAMS_SVH
`define RS_PARAMS_SVH

// operand and result width
`define RS_DATA_W 32

// station geometry
`define RS_SIZE 8
`define RS_IDX_W 3

// architectural register name width
`define RS_NAME_W 5

// producer unit codes carried in every tag
`define RS_UNIT_ALU 1'b0
`define RS_UNIT_LS 1'b1

`endif

//--- common/rsPkg.sv
`include "rs_params.svh"

package rsPkg;

    // busy=0 means the value is already present
    typedef struct packed {
        logic busy;
        logic unit;
        logic [`RS_IDX_W-1:0] idx;
    } tag_t;

    typedef struct packed {
        tag_t tag;
        logic [`RS_DATA_W-1:0] data;
    } operand_t;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } aluOp_t;

    typedef struct packed {
        aluOp_t op;
        operand_t srcO;
        operand_t srcT;
        logic [`RS_NAME_W-1:0] name;
    } dispatch_t;

    typedef struct packed {
        logic valid;
        aluOp_t op;
        logic [`RS_DATA_W-1:0] dataO;
        logic [`RS_DATA_W-1:0] dataT;
        tag_t tag;
        logic [`RS_NAME_W-1:0] name;
    } issue_t;

    // shared by the ALU and load/store broadcast buses
    typedef struct packed {
        logic valid;
        tag_t tag;
        logic [`RS_NAME_W-1:0] name;
        logic [`RS_DATA_W-1:0] data;
    } result_t;

endpackage

//--- rs/rsEntry.sv
`timescale 1ns/1ps
`include "rs_params.svh"

module rsEntry (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   alloc,
    input  rsPkg::dispatch_t       allocData,
    input  rsPkg::result_t         aluBus,
    input  rsPkg::result_t         lsBus,
    input  logic                   occupied,
    output logic                   ready,
    output rsPkg::aluOp_t          entryOp,
    output logic [`RS_NAME_W-1:0]  entryName,
    output logic [`RS_DATA_W-1:0]  operandO,
    output logic [`RS_DATA_W-1:0]  operandT
);

    rsPkg::tag_t tagO;
    rsPkg::tag_t tagT;
    logic [`RS_DATA_W-1:0] dataO;
    logic [`RS_DATA_W-1:0] dataT;
    rsPkg::aluOp_t op;
    logic [`RS_NAME_W-1:0] name;

    rsPkg::operand_t nextO;
    rsPkg::operand_t nextT;
    rsPkg::operand_t allocO;
    rsPkg::operand_t allocT;

    // ALU bus wins when both carry the same tag
    function automatic rsPkg::operand_t snoop(
        input rsPkg::operand_t cur,
        input rsPkg::result_t  aBus,
        input rsPkg::result_t  lBus
    );
        rsPkg::operand_t res;
        res = cur;
        if (cur.tag.busy) begin
            if (aBus.valid && aBus.tag == cur.tag) begin
                res.data = aBus.data;
                res.tag = '0;
            end else if (lBus.valid && lBus.tag == cur.tag) begin
                res.data = lBus.data;
                res.tag = '0;
            end
        end
        return res;
    endfunction

    always_comb begin
        nextO = snoop('{tag: tagO, data: dataO}, aluBus, lsBus);
        nextT = snoop('{tag: tagT, data: dataT}, aluBus, lsBus);
        // incoming operands also see this cycle's broadcasts
        allocO = snoop(allocData.srcO, aluBus, lsBus);
        allocT = snoop(allocData.srcT, aluBus, lsBus);
    end

    assign ready = occupied && !nextO.tag.busy && !nextT.tag.busy;
    assign operandO = nextO.data;
    assign operandT = nextT.data;
    assign entryOp = op;
    assign entryName = name;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tagO <= '0;
            tagT <= '0;
        end else if (alloc) begin
            tagO <= allocO.tag;
            tagT <= allocT.tag;
        end else begin
            tagO <= nextO.tag;
            tagT <= nextT.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            dataO <= allocO.data;
            dataT <= allocT.data;
            op <= allocData.op;
            name <= allocData.name;
        end else begin
            dataO <= nextO.data;
            dataT <= nextT.data;
        end
    end

endmodule

//--- rs/aluRs.sv
`timescale 1ns/1ps
`include "rs_params.svh"

module aluRs (
    input  logic             clk,
    input  logic             rst,
    input  logic             dispatchValid,
    input  rsPkg::dispatch_t dispatch,
    output logic             free,
    output rsPkg::tag_t      allocTag,
    input  rsPkg::result_t   aluBus,
    input  rsPkg::result_t   lsBus,
    output rsPkg::issue_t    issue
);

    logic [`RS_SIZE-1:0] occupied;
    logic [`RS_SIZE-1:0] ready;
    logic [`RS_SIZE-1:0] allocVec;
    logic [`RS_SIZE-1:0] issueVec;

    logic [`RS_IDX_W-1:0] freeIdx;
    logic [`RS_IDX_W-1:0] readyIdx;
    logic anyReady;
    logic accept;

    rsPkg::aluOp_t         entryOp   [`RS_SIZE];
    logic [`RS_NAME_W-1:0] entryName [`RS_SIZE];
    logic [`RS_DATA_W-1:0] operandO  [`RS_SIZE];
    logic [`RS_DATA_W-1:0] operandT  [`RS_SIZE];

    logic                  issueValid;
    rsPkg::aluOp_t         issueOp;
    logic [`RS_DATA_W-1:0] issueDataO;
    logic [`RS_DATA_W-1:0] issueDataT;
    rsPkg::tag_t           issueTag;
    logic [`RS_NAME_W-1:0] issueName;

    for (genvar g = 0; g < `RS_SIZE; g++) begin : gEntry
        rsEntry entry (
            .clk       (clk),
            .rst       (rst),
            .alloc     (allocVec[g]),
            .allocData (dispatch),
            .aluBus    (aluBus),
            .lsBus     (lsBus),
            .occupied  (occupied[g]),
            .ready     (ready[g]),
            .entryOp   (entryOp[g]),
            .entryName (entryName[g]),
            .operandO  (operandO[g]),
            .operandT  (operandT[g])
        );
    end

    // lowest empty slot and lowest ready slot
    always_comb begin
        freeIdx = '0;
        readyIdx = '0;
        for (int i = `RS_SIZE - 1; i >= 0; i--) begin
            if (!occupied[i]) begin
                freeIdx = `RS_IDX_W'(i);
            end
            if (ready[i]) begin
                readyIdx = `RS_IDX_W'(i);
            end
        end
    end

    assign free = ~&occupied;
    assign anyReady = |ready;
    assign accept = dispatchValid && free;

    assign allocTag.busy = 1'b1;
    assign allocTag.unit = `RS_UNIT_ALU;
    assign allocTag.idx = freeIdx;

    assign allocVec = accept ? (`RS_SIZE'(1) << freeIdx) : '0;
    assign issueVec = anyReady ? (`RS_SIZE'(1) << readyIdx) : '0;

    // issue and alloc never hit the same slot: alloc only takes empty ones
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            occupied <= '0;
            issueValid <= 1'b0;
        end else begin
            occupied <= (occupied & ~issueVec) | allocVec;
            issueValid <= anyReady;
        end
    end

    always_ff @(posedge clk) begin
        if (anyReady) begin
            issueOp <= entryOp[readyIdx];
            issueDataO <= operandO[readyIdx];
            issueDataT <= operandT[readyIdx];
            issueName <= entryName[readyIdx];
            issueTag.busy <= 1'b1;
            issueTag.unit <= `RS_UNIT_ALU;
            issueTag.idx <= readyIdx;
        end
    end

    always_comb begin
        issue.valid = issueValid;
        issue.op = issueOp;
        issue.dataO = issueDataO;
        issue.dataT = issueDataT;
        issue.tag = issueTag;
        issue.name = issueName;
    end

endmodule

//--- logic/aluExec.sv
`timescale 1ns/1ps
`include "rs_params.svh"

module aluExec (
    input  logic           clk,
    input  logic           rst,
    input  rsPkg::issue_t  issue,
    output rsPkg::result_t result
);

    logic [`RS_DATA_W-1:0] opA;
    logic [`RS_DATA_W-1:0] opB;
    logic [`RS_DATA_W-1:0] aluOut;
    logic [4:0] shamt;
    logic lessThan;

    logic                  resValid;
    rsPkg::tag_t           resTag;
    logic [`RS_NAME_W-1:0] resName;
    logic [`RS_DATA_W-1:0] resData;

    assign opA = issue.dataO;
    assign opB = issue.dataT;
    assign shamt = opB[4:0];
    assign lessThan = $signed(opA) < $signed(opB);

    always_comb begin
        case (issue.op)
            rsPkg::ADD: aluOut = opA + opB;
            rsPkg::SUB: aluOut = opA - opB;
            rsPkg::AND: aluOut = opA & opB;
            rsPkg::OR:  aluOut = opA | opB;
            rsPkg::XOR: aluOut = opA ^ opB;
            rsPkg::SLL: aluOut = opA << shamt;
            rsPkg::SRL: aluOut = opA >> shamt;
            rsPkg::SLT: aluOut = {{(`RS_DATA_W - 1){1'b0}}, lessThan};
            default:    aluOut = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resValid <= 1'b0;
        end else begin
            resValid <= issue.valid;
        end
    end

    // result payload only moves with a valid issue
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            resTag <= issue.tag;
            resName <= issue.name;
            resData <= aluOut;
        end
    end

    always_comb begin
        result.valid = resValid;
        result.tag = resTag;
        result.name = resName;
        result.data = resData;
    end

endmodule

//--- logic/aluCluster.sv
`timescale 1ns/1ps

module aluCluster (
    input  logic             clk,
    input  logic             rst,
    input  logic             dispatchValid,
    input  rsPkg::dispatch_t dispatch,
    output logic             free,
    output rsPkg::tag_t      allocTag,
    input  rsPkg::result_t   lsResult,
    output rsPkg::result_t   aluResult
);

    rsPkg::issue_t issue;

    aluRs station (
        .clk           (clk),
        .rst           (rst),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .free          (free),
        .allocTag      (allocTag),
        .aluBus        (aluResult),
        .lsBus         (lsResult),
        .issue         (issue)
    );

    // ALU result doubles as the station's own wakeup bus
    aluExec alu (
        .clk    (clk),
        .rst    (rst),
        .issue  (issue),
        .result (aluResult)
    );

endmodule

//--- tb/aluCluster_sva.sv
`timescale 1ns/1ps
`include "rs_params.svh"

module aluCluster_sva (
    input logic           clk,
    input logic           rst,
    input logic           dispatchValid,
    input logic           free,
    input rsPkg::result_t aluResult
);

    // every ALU broadcast names one of this station's slots
    assert property (@(posedge clk) disable iff (rst)
        aluResult.valid |-> aluResult.tag.busy && aluResult.tag.unit == `RS_UNIT_ALU)
        else $error("ALU result carries a tag that is not a busy ALU tag");

    // station only fills through an accepted dispatch
    assert property (@(posedge clk) disable iff (rst)
        $fell(free) |-> $past(dispatchValid))
        else $error("station became full without an accepted dispatch");

    // a full station opens a slot only by issuing
    assert property (@(posedge clk) disable iff (rst)
        $rose(free) |=> aluResult.valid)
        else $error("slot freed in a full station without an issued result");

endmodule

bind aluCluster aluCluster_sva rules (
    .clk           (clk),
    .rst           (rst),
    .dispatchValid (dispatchValid),
    .free          (free),
    .aluResult     (aluResult)
);

//--- tb/aluCluster_tb.sv
`timescale 1ns/1ps
`include "rs_params.svh"

module aluCluster_tb;

    // about 100 cycles of tests, so this only trips on a hang
    localparam int maxCycles = 3000;

    logic clk;
    logic rst;
    logic dispatchValid;
    rsPkg::dispatch_t dispatch;
    logic free;
    rsPkg::tag_t allocTag;
    rsPkg::result_t lsResult;
    rsPkg::result_t aluResult;

    int errors = 0;
    int cycleCount = 0;

    aluCluster UUT (
        .clk           (clk),
        .rst           (rst),
        .dispatchValid (dispatchValid),
        .dispatch      (dispatch),
        .free          (free),
        .allocTag      (allocTag),
        .lsResult      (lsResult),
        .aluResult     (aluResult)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("timeout: run went past %0d cycles", maxCycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [`RS_DATA_W-1:0] aluModel(input rsPkg::aluOp_t op,
                                                       input logic [`RS_DATA_W-1:0] a,
                                                       input logic [`RS_DATA_W-1:0] b);
        case (op)
            rsPkg::ADD: return a + b;
            rsPkg::SUB: return a - b;
            rsPkg::AND: return a & b;
            rsPkg::OR:  return a | b;
            rsPkg::XOR: return a ^ b;
            rsPkg::SLL: return a << b[4:0];
            rsPkg::SRL: return a >> b[4:0];
            default:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic rsPkg::tag_t aluTag(input int idx);
        rsPkg::tag_t t;
        t.busy = 1'b1;
        t.unit = `RS_UNIT_ALU;
        t.idx = `RS_IDX_W'(idx);
        return t;
    endfunction

    function automatic rsPkg::tag_t lsTag(input int idx);
        rsPkg::tag_t t;
        t.busy = 1'b1;
        t.unit = `RS_UNIT_LS;
        t.idx = `RS_IDX_W'(idx);
        return t;
    endfunction

    function automatic rsPkg::operand_t present(input logic [`RS_DATA_W-1:0] data);
        rsPkg::operand_t o;
        o.tag = '0;
        o.data = data;
        return o;
    endfunction

    function automatic rsPkg::operand_t waiting(input rsPkg::tag_t t);
        rsPkg::operand_t o;
        o.tag = t;
        o.data = '0;
        return o;
    endfunction

    function automatic rsPkg::result_t makeResult(input rsPkg::tag_t t,
                                                  input logic [`RS_NAME_W-1:0] name,
                                                  input logic [`RS_DATA_W-1:0] data);
        rsPkg::result_t r;
        r.valid = 1'b1;
        r.tag = t;
        r.name = name;
        r.data = data;
        return r;
    endfunction

    task automatic checkResult(input string sig, input rsPkg::result_t got,
                               input rsPkg::result_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s got %h, expected %h", $time, sig, got, exp);
            errors++;
        end
    endtask

    task automatic checkTag(input string sig, input rsPkg::tag_t got, input rsPkg::tag_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s got %h, expected %h", $time, sig, got, exp);
            errors++;
        end
    endtask

    task automatic checkFlag(input string sig, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s got %b, expected %b", $time, sig, got, exp);
            errors++;
        end
    endtask

    // outputs settle right after the edge, inputs change here too
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic dispatchOne(input rsPkg::dispatch_t d, input rsPkg::result_t ls,
                               input int expIdx, output rsPkg::tag_t t);
        int n;
        n = 0;
        while (!free && n < 20) begin
            tick();
            n++;
        end
        if (!free) begin
            $display("station never offered a free slot for dispatch");
            errors++;
        end
        checkTag("allocTag", allocTag, aluTag(expIdx));
        t = aluTag(expIdx);
        dispatchValid = 1'b1;
        dispatch = d;
        lsResult = ls;
        tick();
        dispatchValid = 1'b0;
        lsResult = '0;
    endtask

    task automatic broadcastLs(input rsPkg::result_t r);
        lsResult = r;
        tick();
        lsResult = '0;
    endtask

    task automatic waitResult(input rsPkg::result_t exp, input int limit);
        int n;
        n = 0;
        tick();
        while (!aluResult.valid && n < limit) begin
            tick();
            n++;
        end
        if (aluResult.valid) begin
            checkResult("aluResult", aluResult, exp);
        end else begin
            $display("no ALU result for tag %h within %0d cycles", exp.tag, limit);
            errors++;
        end
    endtask

    task automatic testReset();
        checkFlag("free", free, 1'b1);
        checkTag("allocTag", allocTag, aluTag(0));
        checkFlag("aluResult.valid", aluResult.valid, 1'b0);
    endtask

    task automatic testReadyOps();
        rsPkg::dispatch_t d;
        rsPkg::tag_t t;
        logic [`RS_DATA_W-1:0] a;
        logic [`RS_DATA_W-1:0] b;
        for (int i = 0; i < 8; i++) begin
            a = $urandom();
            b = $urandom();
            d.op = rsPkg::aluOp_t'(3'(i));
            d.srcO = present(a);
            d.srcT = present(b);
            d.name = `RS_NAME_W'(i + 1);
            dispatchOne(d, '0, 0, t);
            tick();
            checkFlag("aluResult.valid", aluResult.valid, 1'b0);
            tick();
            checkResult("aluResult", aluResult, makeResult(t, d.name, aluModel(d.op, a, b)));
        end
    endtask

    task automatic testLsWakeup();
        rsPkg::dispatch_t d;
        rsPkg::tag_t t;
        logic [`RS_DATA_W-1:0] a;
        logic [`RS_DATA_W-1:0] b;
        a = $urandom();
        b = $urandom();
        d.op = rsPkg::SUB;
        d.srcO = waiting(lsTag(3));
        d.srcT = present(b);
        d.name = `RS_NAME_W'(9);
        dispatchOne(d, '0, 0, t);
        // another load/store tag must not wake it
        broadcastLs(makeResult(lsTag(4), '0, $urandom()));
        repeat (4) begin
            tick();
            checkFlag("aluResult.valid", aluResult.valid, 1'b0);
        end
        broadcastLs(makeResult(lsTag(3), '0, a));
        waitResult(makeResult(t, d.name, aluModel(rsPkg::SUB, a, b)), 4);
    endtask

    task automatic testAluDependency();
        rsPkg::dispatch_t first;
        rsPkg::dispatch_t second;
        rsPkg::tag_t tFirst;
        rsPkg::tag_t tSecond;
        logic [`RS_DATA_W-1:0] a;
        logic [`RS_DATA_W-1:0] b;
        logic [`RS_DATA_W-1:0] c;
        a = $urandom();
        b = $urandom();
        c = $urandom();
        first.op = rsPkg::XOR;
        first.srcO = present(a);
        first.srcT = present(b);
        first.name = `RS_NAME_W'(3);
        dispatchOne(first, '0, 0, tFirst);
        second.op = rsPkg::ADD;
        second.srcO = waiting(tFirst);
        second.srcT = present(c);
        second.name = `RS_NAME_W'(4);
        // slot 0 is still held by the first instruction
        dispatchOne(second, '0, 1, tSecond);
        waitResult(makeResult(tFirst, first.name, aluModel(first.op, a, b)), 4);
        waitResult(makeResult(tSecond, second.name,
                              aluModel(second.op, aluModel(first.op, a, b), c)), 4);
    endtask

    task automatic testFullStation();
        rsPkg::dispatch_t d;
        rsPkg::tag_t tags [`RS_SIZE];
        rsPkg::dispatch_t held [`RS_SIZE];
        logic [`RS_DATA_W-1:0] a;
        for (int i = 0; i < `RS_SIZE; i++) begin
            d.op = rsPkg::aluOp_t'(3'(i));
            d.srcO = waiting(lsTag(i));
            d.srcT = present($urandom());
            d.name = `RS_NAME_W'(i + 10);
            held[i] = d;
            dispatchOne(d, '0, i, tags[i]);
        end
        checkFlag("free", free, 1'b0);
        // a full station has to hold this one off
        d.op = rsPkg::ADD;
        d.srcO = present($urandom());
        d.srcT = present($urandom());
        d.name = `RS_NAME_W'(31);
        dispatchValid = 1'b1;
        dispatch = d;
        tick();
        dispatchValid = 1'b0;
        checkFlag("free", free, 1'b0);
        for (int k = `RS_SIZE - 1; k >= 0; k--) begin
            a = $urandom();
            broadcastLs(makeResult(lsTag(k), '0, a));
            waitResult(makeResult(tags[k], held[k].name,
                                  aluModel(held[k].op, a, held[k].srcT.data)), 4);
        end
        checkFlag("free", free, 1'b1);
    endtask

    task automatic testDispatchBroadcast();
        rsPkg::dispatch_t d;
        rsPkg::tag_t t;
        logic [`RS_DATA_W-1:0] a;
        logic [`RS_DATA_W-1:0] b;
        a = $urandom();
        b = $urandom();
        d.op = rsPkg::SLT;
        d.srcO = waiting(lsTag(5));
        d.srcT = present(b);
        d.name = `RS_NAME_W'(30);
        dispatchOne(d, makeResult(lsTag(5), '0, a), 0, t);
        waitResult(makeResult(t, d.name, aluModel(rsPkg::SLT, a, b)), 4);
    endtask

    initial begin
        void'($urandom(32'hc726_a225));
        clk = 1'b0;
        rst = 1'b1;
        dispatchValid = 1'b0;
        dispatch = '0;
        lsResult = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        testReset();
        testReadyOps();
        testLsWakeup();
        testAluDependency();
        testFullStation();
        testDispatchBroadcast();

        $display("run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- aluCluster.f
+incdir+common
common/rsPkg.sv
rs/rsEntry.sv
rs/aluRs.sv
logic/aluExec.sv
logic/aluCluster.sv
tb/aluCluster_sva.sv
tb/aluCluster_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module aluCluster_tb -f aluCluster.f -o aluCluster_sim

out=$(./obj_dir/aluCluster_sim)
echo "$out"
if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
